// File: tetris_cfg.svh
`ifndef TETRIS_CFG_SVH
`define TETRIS_CFG_SVH

// playfield size in cells, row 0 at the top
`define FIELD_ROWS 20
`define FIELD_COLS 10

// bits per cell, zero is an empty cell
`define COLOR_W 3

// top-left corner of the 4x4 piece box at spawn
`define SPAWN_ROW 0
`define SPAWN_COL 3

`endif

// File: tetris_pkg.sv
`include "tetris_cfg.svh"

package tetris_pkg;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    SPAWN,
    PLAY,
    WAIT_FIT,
    CLEAR,
    GAME_OVER
  } game_state_t;

  // request kinds sent to the planner
  typedef enum logic [2:0] {
    MV_NONE,
    MV_RIGHT,
    MV_LEFT,
    MV_ROR,
    MV_ROL,
    MV_DOWN,
    MV_SPAWN
  } move_t;

  // tetromino kinds in spawn order
  typedef enum logic [2:0] {I, O, T, S, Z, J, L} piece_t;

  typedef logic [`COLOR_W-1:0] color_t;

  // 4x4 box mask, bit 4*row+col, bit 0 top-left
  // table entries packed as {rot3, rot2, rot1, rot0}
  function automatic logic [15:0] shape_of(piece_t kind, logic [1:0] rot);
    logic [3:0][15:0] tbl;
    case (kind)
      I:       tbl = {16'h2222, 16'h00F0, 16'h4444, 16'h000F};
      O:       tbl = {4{16'h0066}};
      T:       tbl = {16'h0232, 16'h0270, 16'h0262, 16'h0072};
      S:       tbl = {16'h0231, 16'h0360, 16'h0462, 16'h0036};
      Z:       tbl = {16'h0132, 16'h0630, 16'h0264, 16'h0063};
      J:       tbl = {16'h0322, 16'h0470, 16'h0226, 16'h0071};
      L:       tbl = {16'h0223, 16'h0170, 16'h0622, 16'h0074};
      default: tbl = '0;
    endcase
    return tbl[rot];
  endfunction

  // cell color of a kind, never zero
  function automatic color_t color_of(piece_t kind);
    return color_t'(kind) + color_t'(1);
  endfunction

endpackage

// File: move_planner.sv
`timescale 1ns/10ps
`include "tetris_cfg.svh"

module move_planner (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid_i,
  input  tetris_pkg::move_t  req_move_i,
  input  logic [4:0]         row_i,
  input  logic signed [4:0]  col_i,
  input  logic [1:0]         rot_i,
  input  tetris_pkg::piece_t kind_i,
  output logic               cand_valid_o,
  output logic [4:0]         cand_row_o,
  output logic signed [4:0]  cand_col_o,
  output logic [1:0]         cand_rot_o,
  output logic [15:0]        cand_mask_o
);

  logic [4:0]        nxt_row;
  logic signed [4:0] nxt_col;
  logic [1:0]        nxt_rot;

  // apply the move to the current position
  always_comb begin
    nxt_row = row_i;
    nxt_col = col_i;
    nxt_rot = rot_i;
    case (req_move_i)
      tetris_pkg::MV_RIGHT: nxt_col = col_i + 5'sd1;
      tetris_pkg::MV_LEFT:  nxt_col = col_i - 5'sd1;
      tetris_pkg::MV_ROR:   nxt_rot = rot_i + 2'd1;
      tetris_pkg::MV_ROL:   nxt_rot = rot_i - 2'd1;
      tetris_pkg::MV_DOWN:  nxt_row = row_i + 5'd1;
      tetris_pkg::MV_SPAWN: begin
        nxt_row = 5'(`SPAWN_ROW);
        nxt_col = 5'(`SPAWN_COL);
        nxt_rot = 2'd0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cand_valid_o <= 1'b0;
    end else begin
      cand_valid_o <= req_valid_i;
    end
  end

  // candidate holds until the next request
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      cand_row_o  <= nxt_row;
      cand_col_o  <= nxt_col;
      cand_rot_o  <= nxt_rot;
      cand_mask_o <= tetris_pkg::shape_of(kind_i, nxt_rot);
    end
  end

endmodule

// File: collision_check.sv
`timescale 1ns/10ps
`include "tetris_cfg.svh"

module collision_check (
  input  logic              clk,
  input  logic              rst,
  input  logic              cand_valid_i,
  input  logic [4:0]        cand_row_i,
  input  logic signed [4:0] cand_col_i,
  input  logic [15:0]       cand_mask_i,
  input  tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] field_i,
  output logic              fit_valid_o,
  output logic              fit_o
);

  logic fits;

  // every set box cell must land on the field and on an empty cell
  always_comb begin
    logic [5:0]        r;
    logic signed [5:0] c;
    fits = 1'b1;
    for (int i = 0; i < 16; i++) begin
      r = {1'b0, cand_row_i} + 6'(i / 4);
      c = 6'(cand_col_i) + 6'(i % 4);
      if (cand_mask_i[i]) begin
        if (r >= 6'(`FIELD_ROWS) || c < 0 || c >= `FIELD_COLS) begin
          fits = 1'b0;
        end else if (field_i[r[4:0]][c[3:0]] != '0) begin
          fits = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fit_valid_o <= 1'b0;
    end else begin
      fit_valid_o <= cand_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (cand_valid_i) begin
      fit_o <= fits;
    end
  end

endmodule

// File: line_clear.sv
`timescale 1ns/10ps
`include "tetris_cfg.svh"

module line_clear (
  input  logic       clk,
  input  logic       rst,
  input  logic       clear_start_i,
  input  tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] field_i,
  output logic       clear_done_o,
  output tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] field_o,
  output logic [4:0] removed_o
);

  tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] work;
  logic       busy;
  logic [4:0] row_q;
  logic       row_full;

  assign field_o = work;

  // row under the scan pointer has no empty cell
  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < `FIELD_COLS; c++) begin
      if (work[row_q][c] == '0) begin
        row_full = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // scan control, bottom row upward
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy         <= 1'b0;
      row_q        <= '0;
      removed_o    <= '0;
      clear_done_o <= 1'b0;
    end else begin
      clear_done_o <= 1'b0;
      if (clear_start_i) begin
        busy      <= 1'b1;
        row_q     <= 5'(`FIELD_ROWS - 1);
        removed_o <= '0;
      end else if (busy) begin
        // a full row is collapsed, then the same row is scanned again
        if (row_full) begin
          removed_o <= removed_o + 5'd1;
        end else if (row_q == '0) begin
          busy         <= 1'b0;
          clear_done_o <= 1'b1;
        end else begin
          row_q <= row_q - 5'd1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // working copy of the field
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (clear_start_i) begin
      work <= field_i;
    end else if (busy && row_full) begin
      // rows above drop by one, empty row enters at the top
      for (int r = 1; r < `FIELD_ROWS; r++) begin
        if (r <= int'(row_q)) begin
          work[r] <= work[r-1];
        end
      end
      work[0] <= '0;
    end
  end

endmodule

// File: tetris_fsm.sv
`timescale 1ns/10ps
`include "tetris_cfg.svh"

module tetris_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start_i,
  input  logic                    right_i, left_i, rot_r_i, rot_l_i, down_i,
  input  logic [4:0]              cand_row_i,
  input  logic signed [4:0]       cand_col_i,
  input  logic [1:0]              cand_rot_i,
  input  logic                    fit_valid_i,
  input  logic                    fit_i,
  input  logic                    clear_done_i,
  input  tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] cleared_field_i,
  input  logic [4:0]              removed_i,
  output logic                    req_valid_o,
  output tetris_pkg::move_t       req_move_o,
  output logic [4:0]              row_o,
  output logic signed [4:0]       col_o,
  output logic [1:0]              rot_o,
  output tetris_pkg::piece_t      kind_o,
  output logic                    clear_start_o,
  output tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] field_o,
  output tetris_pkg::game_state_t state_o,
  output logic [7:0]              lines_o,
  output logic                    game_over_o
);

  tetris_pkg::game_state_t state;
  tetris_pkg::move_t       pend_move;
  tetris_pkg::piece_t      kind_cnt;
  tetris_pkg::piece_t      next_kind;
  tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] locked;

  assign state_o     = state;
  assign game_over_o = (state == tetris_pkg::GAME_OVER);
  assign next_kind   = (kind_cnt == tetris_pkg::L) ? tetris_pkg::I :
                       tetris_pkg::piece_t'(kind_cnt + 3'd1);

  ////////////////////////////////////////////////////////////
  // request issue
  ////////////////////////////////////////////////////////////
  // spawn in SPAWN, otherwise one prioritized move while idle in play
  always_comb begin
    req_valid_o = 1'b1;
    req_move_o  = tetris_pkg::MV_NONE;
    if (state == tetris_pkg::SPAWN) begin
      req_move_o = tetris_pkg::MV_SPAWN;
    end else if (state == tetris_pkg::PLAY && right_i) begin
      req_move_o = tetris_pkg::MV_RIGHT;
    end else if (state == tetris_pkg::PLAY && left_i) begin
      req_move_o = tetris_pkg::MV_LEFT;
    end else if (state == tetris_pkg::PLAY && rot_r_i) begin
      req_move_o = tetris_pkg::MV_ROR;
    end else if (state == tetris_pkg::PLAY && rot_l_i) begin
      req_move_o = tetris_pkg::MV_ROL;
    end else if (state == tetris_pkg::PLAY && down_i) begin
      req_move_o = tetris_pkg::MV_DOWN;
    end else begin
      req_valid_o = 1'b0;
    end
  end

  // field with the active piece written in
  always_comb begin
    logic [15:0]       mask;
    logic [5:0]        r;
    logic signed [5:0] c;
    locked = field_o;
    mask   = tetris_pkg::shape_of(kind_o, rot_o);
    for (int i = 0; i < 16; i++) begin
      r = {1'b0, row_o} + 6'(i / 4);
      c = 6'(col_o) + 6'(i % 4);
      if (mask[i] && r < 6'(`FIELD_ROWS) && c >= 0 && c < `FIELD_COLS) begin
        locked[r[4:0]][c[3:0]] = tetris_pkg::color_of(kind_o);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // game state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= tetris_pkg::IDLE;
      pend_move     <= tetris_pkg::MV_NONE;
      kind_cnt      <= tetris_pkg::I;
      kind_o        <= tetris_pkg::I;
      row_o         <= '0;
      col_o         <= '0;
      rot_o         <= '0;
      field_o       <= '0;
      lines_o       <= '0;
      clear_start_o <= 1'b0;
    end else begin
      clear_start_o <= 1'b0;
      if (req_valid_o) begin
        pend_move <= req_move_o;
      end
      case (state)
        tetris_pkg::IDLE: begin
          if (start_i) begin
            kind_o   <= kind_cnt;
            kind_cnt <= next_kind;
            state    <= tetris_pkg::SPAWN;
          end
        end
        tetris_pkg::SPAWN: state <= tetris_pkg::WAIT_FIT;
        tetris_pkg::PLAY: begin
          if (req_valid_o) begin
            state <= tetris_pkg::WAIT_FIT;
          end
        end
        tetris_pkg::WAIT_FIT: begin
          if (fit_valid_i && fit_i) begin
            row_o <= cand_row_i;
            col_o <= cand_col_i;
            rot_o <= cand_rot_i;
            state <= tetris_pkg::PLAY;
          end else if (fit_valid_i && pend_move == tetris_pkg::MV_SPAWN) begin
            state <= tetris_pkg::GAME_OVER;
          end else if (fit_valid_i && pend_move == tetris_pkg::MV_DOWN) begin
            // piece rests here, lock it and look for full rows
            field_o       <= locked;
            clear_start_o <= 1'b1;
            state         <= tetris_pkg::CLEAR;
          end else if (fit_valid_i) begin
            state <= tetris_pkg::PLAY;
          end
        end
        tetris_pkg::CLEAR: begin
          if (clear_done_i) begin
            field_o  <= cleared_field_i;
            lines_o  <= lines_o + 8'(removed_i);
            kind_o   <= kind_cnt;
            kind_cnt <= next_kind;
            state    <= tetris_pkg::SPAWN;
          end
        end
        tetris_pkg::GAME_OVER: begin
          if (start_i) begin
            field_o  <= '0;
            lines_o  <= '0;
            kind_cnt <= tetris_pkg::I;
            state    <= tetris_pkg::IDLE;
          end
        end
        default: state <= tetris_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: tetris_top.sv
`timescale 1ns/10ps
`include "tetris_cfg.svh"

module tetris_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start_i,
  input  logic                    right_i, left_i, rot_r_i, rot_l_i, down_i,
  output tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] field_o,
  output tetris_pkg::piece_t      piece_kind_o,
  output logic [1:0]              piece_rot_o,
  output logic [4:0]              piece_row_o,
  output logic signed [4:0]       piece_col_o,
  output tetris_pkg::game_state_t state_o,
  output logic [7:0]              lines_o,
  output logic                    game_over_o
);

  // request path
  logic              req_valid, cand_valid, fit_valid, fit;
  tetris_pkg::move_t req_move;
  logic [4:0]        cand_row;
  logic signed [4:0] cand_col;
  logic [1:0]        cand_rot;
  logic [15:0]       cand_mask;

  // line clear path
  logic              clear_start, clear_done;
  logic [4:0]        removed;
  tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] cleared_field;

  tetris_fsm u_fsm (
    .clk(clk), .rst(rst), .start_i(start_i),
    .right_i(right_i), .left_i(left_i), .rot_r_i(rot_r_i), .rot_l_i(rot_l_i),
    .down_i(down_i),
    .cand_row_i(cand_row), .cand_col_i(cand_col), .cand_rot_i(cand_rot),
    .fit_valid_i(fit_valid), .fit_i(fit),
    .clear_done_i(clear_done), .cleared_field_i(cleared_field), .removed_i(removed),
    .req_valid_o(req_valid), .req_move_o(req_move),
    .row_o(piece_row_o), .col_o(piece_col_o), .rot_o(piece_rot_o), .kind_o(piece_kind_o),
    .clear_start_o(clear_start), .field_o(field_o),
    .state_o(state_o), .lines_o(lines_o), .game_over_o(game_over_o)
  );

  move_planner u_planner (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid), .req_move_i(req_move),
    .row_i(piece_row_o), .col_i(piece_col_o), .rot_i(piece_rot_o), .kind_i(piece_kind_o),
    .cand_valid_o(cand_valid), .cand_row_o(cand_row), .cand_col_o(cand_col),
    .cand_rot_o(cand_rot), .cand_mask_o(cand_mask)
  );

  collision_check u_collision (
    .clk(clk), .rst(rst),
    .cand_valid_i(cand_valid), .cand_row_i(cand_row), .cand_col_i(cand_col),
    .cand_mask_i(cand_mask), .field_i(field_o),
    .fit_valid_o(fit_valid), .fit_o(fit)
  );

  line_clear u_clear (
    .clk(clk), .rst(rst),
    .clear_start_i(clear_start), .field_i(field_o),
    .clear_done_o(clear_done), .field_o(cleared_field), .removed_o(removed)
  );

endmodule

// File: tb_tetris.sv
`timescale 1ns/10ps
`include "tetris_cfg.svh"

module tb_tetris;

  typedef tetris_pkg::color_t [`FIELD_ROWS-1:0][`FIELD_COLS-1:0] field_t;

  logic                    clk;
  logic                    rst;
  logic                    start_i, right_i, left_i, rot_r_i, rot_l_i, down_i;
  field_t                  field_o;
  tetris_pkg::piece_t      piece_kind_o;
  logic [1:0]              piece_rot_o;
  logic [4:0]              piece_row_o;
  logic signed [4:0]       piece_col_o;
  tetris_pkg::game_state_t state_o;
  logic [7:0]              lines_o;
  logic                    game_over_o;

  // reference model
  field_t                  exp_field;
  tetris_pkg::piece_t      exp_kind;
  tetris_pkg::game_state_t exp_state;
  logic [1:0]              exp_rot;
  int                      exp_row, exp_col, exp_lines, kind_idx;
  tetris_pkg::piece_t      kind_order [7] = '{tetris_pkg::I, tetris_pkg::O, tetris_pkg::T,
                                              tetris_pkg::S, tetris_pkg::Z, tetris_pkg::J,
                                              tetris_pkg::L};
  logic                    chk_pos, chk_field, chk_state;
  logic                    full_row;
  string                   test_name;

  tetris_top DUT (
    .clk(clk), .rst(rst), .start_i(start_i),
    .right_i(right_i), .left_i(left_i), .rot_r_i(rot_r_i), .rot_l_i(rot_l_i),
    .down_i(down_i),
    .field_o(field_o), .piece_kind_o(piece_kind_o), .piece_rot_o(piece_rot_o),
    .piece_row_o(piece_row_o), .piece_col_o(piece_col_o), .state_o(state_o),
    .lines_o(lines_o), .game_over_o(game_over_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input int exp_v, input int act_v);
    fail_with($sformatf("MISMATCH test=%s %s expected=%0d actual=%0d",
                        test_name, what, exp_v, act_v));
  endtask

  // any row with no empty cell
  always_comb begin
    logic row_full;
    full_row = 1'b0;
    for (int r = 0; r < `FIELD_ROWS; r++) begin
      row_full = 1'b1;
      for (int c = 0; c < `FIELD_COLS; c++) begin
        if (field_o[r][c] == '0) begin
          row_full = 1'b0;
        end
      end
      if (row_full) begin
        full_row = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks against the model
  ////////////////////////////////////////////////////////////
  a_kind: assert property (@(posedge clk) disable iff (rst)
    chk_pos |-> piece_kind_o == exp_kind)
    else report_mismatch("kind", int'(exp_kind), int'(piece_kind_o));
  a_row: assert property (@(posedge clk) disable iff (rst)
    chk_pos |-> int'(piece_row_o) == exp_row)
    else report_mismatch("row", exp_row, int'(piece_row_o));
  a_col: assert property (@(posedge clk) disable iff (rst)
    chk_pos |-> int'(piece_col_o) == exp_col)
    else report_mismatch("col", exp_col, int'(piece_col_o));
  a_rot: assert property (@(posedge clk) disable iff (rst)
    chk_pos |-> piece_rot_o == exp_rot)
    else report_mismatch("rot", int'(exp_rot), int'(piece_rot_o));
  a_field: assert property (@(posedge clk) disable iff (rst)
    chk_field |-> field_o == exp_field)
    else fail_with($sformatf("MISMATCH test=%s field expected=%h actual=%h",
                             test_name, exp_field, field_o));
  a_lines: assert property (@(posedge clk) disable iff (rst)
    chk_field |-> int'(lines_o) == exp_lines)
    else report_mismatch("lines", exp_lines, int'(lines_o));
  a_state: assert property (@(posedge clk) disable iff (rst)
    chk_state |-> state_o == exp_state)
    else report_mismatch("state", int'(exp_state), int'(state_o));
  a_game_over: assert property (@(posedge clk) disable iff (rst)
    chk_state |-> game_over_o == (exp_state == tetris_pkg::GAME_OVER))
    else report_mismatch("game_over", int'(exp_state == tetris_pkg::GAME_OVER),
                         int'(game_over_o));
  a_no_full_row: assert property (@(posedge clk) disable iff (rst)
    state_o == tetris_pkg::PLAY |-> !full_row)
    else fail_with($sformatf("test %s: a full row remained in the field during play",
                             test_name));

  ////////////////////////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////////////////////////
  function automatic logic piece_fits(input tetris_pkg::piece_t kind, input logic [1:0] rot,
                                      input int row, input int col, input field_t f);
    logic [15:0] mask;
    int          r;
    int          c;
    logic        ok;
    mask = tetris_pkg::shape_of(kind, rot);
    ok = 1'b1;
    for (int i = 0; i < 16; i++) begin
      r = row + i / 4;
      c = col + i % 4;
      if (mask[i]) begin
        if (r < 0 || r >= `FIELD_ROWS || c < 0 || c >= `FIELD_COLS) begin
          ok = 1'b0;
        end else if (f[r][c] != '0) begin
          ok = 1'b0;
        end
      end
    end
    return ok;
  endfunction

  // drop full rows, keep the rest in order at the bottom
  function automatic field_t collapse_rows(input field_t f, output int n);
    field_t dst;
    int     w;
    logic   full;
    dst = '0;
    n = 0;
    w = `FIELD_ROWS - 1;
    for (int r = `FIELD_ROWS - 1; r >= 0; r--) begin
      full = 1'b1;
      for (int c = 0; c < `FIELD_COLS; c++) begin
        if (f[r][c] == '0) begin
          full = 1'b0;
        end
      end
      if (full) begin
        n++;
      end else begin
        dst[w] = f[r];
        w--;
      end
    end
    return dst;
  endfunction

  // cell color is the kind value plus one
  task automatic lock_piece();
    logic [15:0] mask;
    mask = tetris_pkg::shape_of(exp_kind, exp_rot);
    for (int i = 0; i < 16; i++) begin
      if (mask[i]) begin
        exp_field[exp_row + i / 4][exp_col + i % 4] = tetris_pkg::color_t'(int'(exp_kind) + 1);
      end
    end
  endtask

  task automatic spawn_piece();
    exp_kind = kind_order[kind_idx];
    kind_idx = (kind_idx + 1) % 7;
    exp_row = `SPAWN_ROW;
    exp_col = `SPAWN_COL;
    exp_rot = 2'd0;
    if (piece_fits(exp_kind, exp_rot, exp_row, exp_col, exp_field)) begin
      exp_state = tetris_pkg::PLAY;
    end else begin
      exp_state = tetris_pkg::GAME_OVER;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  // called at a falling edge, checks land on the next rising edge
  task automatic run_checks(input logic pos, input logic fld);
    chk_pos = pos;
    chk_field = fld;
    chk_state = 1'b1;
    @(negedge clk);
    chk_pos = 1'b0;
    chk_field = 1'b0;
    chk_state = 1'b0;
  endtask

  task automatic wait_for_state(input tetris_pkg::game_state_t a,
                                input tetris_pkg::game_state_t b, input string what);
    logic hit;
    hit = 1'b0;
    for (int n = 0; n < 200 && !hit; n++) begin
      @(negedge clk);
      hit = (state_o == a) || (state_o == b);
    end
    if (!hit) begin
      fail_with($sformatf("timeout in test %s while waiting for %s", test_name, what));
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic start_game();
    pulse_start();
    spawn_piece();
    wait_for_state(tetris_pkg::PLAY, tetris_pkg::GAME_OVER, "first spawn");
    run_checks(exp_state == tetris_pkg::PLAY, 1'b1);
  endtask

  task automatic restart_game();
    pulse_start();
    exp_state = tetris_pkg::IDLE;
    exp_field = '0;
    exp_lines = 0;
    kind_idx = 0;
    wait_for_state(tetris_pkg::IDLE, tetris_pkg::IDLE, "return to idle");
    run_checks(1'b0, 1'b1);
  endtask

  // one move through request, candidate and fit, then compare
  task automatic do_move(input tetris_pkg::move_t mv, output logic got_locked);
    int         c_row;
    int         c_col;
    logic [1:0] c_rot;
    logic       ok;
    int         removed;
    got_locked = 1'b0;
    wait_for_state(tetris_pkg::PLAY, tetris_pkg::PLAY, "play before a move");
    c_row = exp_row;
    c_col = exp_col;
    c_rot = exp_rot;
    case (mv)
      tetris_pkg::MV_RIGHT: c_col = exp_col + 1;
      tetris_pkg::MV_LEFT:  c_col = exp_col - 1;
      tetris_pkg::MV_ROR:   c_rot = exp_rot + 2'd1;
      tetris_pkg::MV_ROL:   c_rot = exp_rot - 2'd1;
      tetris_pkg::MV_DOWN:  c_row = exp_row + 1;
      default: ;
    endcase
    ok = piece_fits(exp_kind, c_rot, c_row, c_col, exp_field);
    @(posedge clk);
    right_i <= (mv == tetris_pkg::MV_RIGHT);
    left_i  <= (mv == tetris_pkg::MV_LEFT);
    rot_r_i <= (mv == tetris_pkg::MV_ROR);
    rot_l_i <= (mv == tetris_pkg::MV_ROL);
    down_i  <= (mv == tetris_pkg::MV_DOWN);
    @(posedge clk);
    right_i <= 1'b0;
    left_i  <= 1'b0;
    rot_r_i <= 1'b0;
    rot_l_i <= 1'b0;
    down_i  <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (ok) begin
      exp_row = c_row;
      exp_col = c_col;
      exp_rot = c_rot;
      run_checks(1'b1, 1'b0);
    end else if (mv == tetris_pkg::MV_DOWN) begin
      // piece rests, then clear and spawn
      lock_piece();
      exp_field = collapse_rows(exp_field, removed);
      exp_lines += removed;
      spawn_piece();
      got_locked = 1'b1;
      wait_for_state(tetris_pkg::PLAY, tetris_pkg::GAME_OVER, "clear and spawn");
      run_checks(exp_state == tetris_pkg::PLAY, 1'b1);
    end else begin
      run_checks(1'b1, 1'b0);
    end
  endtask

  task automatic drop_piece();
    logic done;
    done = 1'b0;
    for (int n = 0; n < `FIELD_ROWS + 4 && !done; n++) begin
      do_move(tetris_pkg::MV_DOWN, done);
    end
    if (!done) begin
      fail_with($sformatf("test %s: piece did not lock after dropping", test_name));
    end
  endtask

  task automatic place_piece(input int n_left, input int n_right,
                             input int n_ror, input int n_rol);
    logic unused;
    repeat (n_ror) do_move(tetris_pkg::MV_ROR, unused);
    repeat (n_rol) do_move(tetris_pkg::MV_ROL, unused);
    repeat (n_left) do_move(tetris_pkg::MV_LEFT, unused);
    repeat (n_right) do_move(tetris_pkg::MV_RIGHT, unused);
    drop_piece();
  endtask

  initial begin
    int n;
    void'($urandom(24));
    rst = 1'b1;
    start_i = 1'b0;
    right_i = 1'b0;
    left_i = 1'b0;
    rot_r_i = 1'b0;
    rot_l_i = 1'b0;
    down_i = 1'b0;
    chk_pos = 1'b0;
    chk_field = 1'b0;
    chk_state = 1'b0;
    exp_field = '0;
    exp_kind = tetris_pkg::I;
    exp_state = tetris_pkg::IDLE;
    exp_rot = 2'd0;
    exp_row = 0;
    exp_col = 0;
    exp_lines = 0;
    kind_idx = 0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    run_checks(1'b0, 1'b1);

    // bottom row from I, O and a final I, the left wall hit by the first I
    test_name = "line_clear";
    start_game();
    place_piece(5, 0, 0, 0);
    place_piece(0, 0, 0, 0);
    repeat (5) place_piece(4, 0, 0, 0);
    // right wall hit on the way to columns 6 to 9
    place_piece(0, 5, 0, 0);
    if (exp_lines != 1) begin
      fail_with("scripted pieces did not complete the bottom row");
    end

    test_name = "random_drops";
    for (n = 0; n < 80 && exp_state != tetris_pkg::GAME_OVER; n++) begin
      place_piece(0, 0, $urandom % 4, $urandom % 2);
    end
    if (exp_state != tetris_pkg::GAME_OVER) begin
      fail_with("random drops never reached game over");
    end

    test_name = "restart";
    restart_game();
    start_game();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: src.f
+incdir+.
tetris_pkg.sv
move_planner.sv
collision_check.sv
line_clear.sv
tetris_fsm.sv
tetris_top.sv
tb_tetris.sv

// File: Makefile
# Verilator flow for the tetris core
VERILATOR ?= verilator
TOP       ?= tb_tetris
RTL_TOP   ?= tetris_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
